// ==== hw/lsq_params.svh ====
// Width, depth and count macros for the store queue slice
`ifndef LSQ_PARAMS_SVH
`define LSQ_PARAMS_SVH

// ====================
// Superscalar widths
// ====================

// Stores dispatched or retired per cycle
`define LSQ_N 2

// Memory units, one load pipe and one execute port each
`define LSQ_NUM_MEM 2

// ====================
// Storage sizes
// ====================

// Store queue depth, kept a power of two so indices wrap for free
`define LSQ_SZ 8
// Data cache size in 32-bit words
`define LSQ_CACHE_WORDS 64
// Byte address and data word widths
`define LSQ_ADDR_W 32
`define LSQ_DATA_W 32

`endif

// ==== hw/lsq_pkg.sv ====
// Vector typedefs, packed structs and the load pipe state enum for the store queue slice
`include "lsq_params.svh"

package lsq_pkg;

    // ====================
    // Plain vectors
    // ====================

    // Byte address and data word
    typedef logic [`LSQ_ADDR_W-1:0] addr_t;
    typedef logic [`LSQ_DATA_W-1:0] data_t;
    // Slot index into the circular queue
    typedef logic [$clog2(`LSQ_SZ)-1:0] sq_idx_t;
    // Slot count, 0 up to a full queue
    typedef logic [$clog2(`LSQ_SZ+1)-1:0] sq_count_t;
    // Stores retired in one cycle
    typedef logic [$clog2(`LSQ_N+1)-1:0] retire_count_t;

    // ====================
    // Bundles
    // ====================

    // Dispatch slot, also the stored queue entry
    typedef struct packed {
        logic  valid;
        addr_t address;
        data_t data;
    } sq_entry_t;

    // Execute update from a memory unit
    typedef struct packed {
        logic    valid;
        sq_idx_t sq_idx;
        addr_t   address;
        data_t   data;
    } sq_exec_t;

    // Forwarding query, sq_tail is the queue tail seen at the load's dispatch
    typedef struct packed {
        logic    valid;
        addr_t   address;
        sq_idx_t sq_tail;
    } sq_lookup_t;

    // Forwarding answer
    typedef struct packed {
        logic  hit;
        logic  stall;
        data_t data;
    } sq_fwd_t;

    // Load request from the core
    typedef struct packed {
        logic    valid;
        addr_t   address;
        sq_idx_t sq_tail;
    } load_req_t;

    // Finished load
    typedef struct packed {
        logic  valid;
        logic  forwarded;
        data_t data;
    } load_result_t;

    // Retire write toward the cache
    typedef struct packed {
        logic  valid;
        addr_t address;
        data_t data;
    } cache_write_t;

    // Load pipe FSM
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        READ
    } load_state_t;

endpackage

// ==== hw/store_queue.sv ====
// Circular store queue with dispatch packing, execute update, retire write-out, flush and forwarding
`timescale 1ns/100ps
`include "lsq_params.svh"

module store_queue (
    input  logic                                     clock,
    input  logic                                     rst_n,
    // Dispatch side
    input  lsq_pkg::sq_entry_t    [`LSQ_N-1:0]       dispatch,
    output lsq_pkg::sq_count_t                       free_slots,
    output lsq_pkg::sq_idx_t      [`LSQ_N-1:0]       alloc_idxs,
    output lsq_pkg::sq_idx_t                         tail_idx,
    // One execute and one lookup port per memory unit
    input  lsq_pkg::sq_exec_t     [`LSQ_NUM_MEM-1:0] exec,
    input  lsq_pkg::sq_lookup_t   [`LSQ_NUM_MEM-1:0] lookup,
    output lsq_pkg::sq_fwd_t      [`LSQ_NUM_MEM-1:0] fwd,
    // Retire side
    input  logic                                     mispredict,
    input  lsq_pkg::retire_count_t                   free_count,
    output logic                                     unexecuted_store,
    output lsq_pkg::cache_write_t [`LSQ_N-1:0]       cache_write
);
    import lsq_pkg::*;

    // Queue storage and per-slot executed bits
    sq_entry_t [`LSQ_SZ-1:0] entries;
    sq_entry_t [`LSQ_SZ-1:0] entries_next;
    logic      [`LSQ_SZ-1:0] executed;
    logic      [`LSQ_SZ-1:0] executed_next;

    // Pointers and free counter
    sq_idx_t   head;
    sq_idx_t   head_next;
    sq_idx_t   tail;
    sq_idx_t   tail_next;
    sq_count_t free_cnt;
    sq_count_t free_next;

    // Stores packed into the tail this cycle
    logic [$clog2(`LSQ_N+1)-1:0] num_disp;

    // Forwarding search scratch
    logic    found;
    sq_idx_t span;
    sq_idx_t idx;

    // ====================
    // Next state
    // ====================

    always_comb begin
        entries_next  = entries;
        executed_next = executed;
        num_disp      = '0;

        // Free the retired head slots
        for (int i = 0; i < `LSQ_N; i++) begin
            if (i < free_count) begin
                entries_next[head + sq_idx_t'(i)].valid = 1'b0;
                executed_next[head + sq_idx_t'(i)]      = 1'b0;
            end
        end
        head_next = head + sq_idx_t'(free_count);

        // Valid slots go to the tail in order, gaps squeezed out
        for (int i = 0; i < `LSQ_N; i++) begin
            if (dispatch[i].valid) begin
                entries_next[tail + sq_idx_t'(num_disp)]  = dispatch[i];
                executed_next[tail + sq_idx_t'(num_disp)] = 1'b0;
                num_disp = num_disp + 1'b1;
            end
        end
        tail_next = tail + sq_idx_t'(num_disp);

        // Address and data arrive from the memory units
        for (int p = 0; p < `LSQ_NUM_MEM; p++) begin
            if (exec[p].valid) begin
                entries_next[exec[p].sq_idx].address = exec[p].address;
                entries_next[exec[p].sq_idx].data    = exec[p].data;
                executed_next[exec[p].sq_idx]        = 1'b1;
            end
        end

        free_next = free_cnt + sq_count_t'(free_count) - sq_count_t'(num_disp);
    end

    // ====================
    // Status outputs
    // ====================

    assign free_slots = free_cnt;
    assign tail_idx   = tail;

    // Slot each dispatch position would land in
    always_comb begin
        for (int i = 0; i < `LSQ_N; i++) begin
            alloc_idxs[i] = tail + sq_idx_t'(i);
        end
    end

    // Any store still waiting on its address or data
    always_comb begin
        unexecuted_store = 1'b0;
        for (int i = 0; i < `LSQ_SZ; i++) begin
            if (entries[i].valid && !executed[i]) begin
                unexecuted_store = 1'b1;
            end
        end
    end

    // Retiring stores go to the cache in the same cycle
    always_comb begin
        for (int i = 0; i < `LSQ_N; i++) begin
            cache_write[i].valid   = (i < free_count);
            cache_write[i].address = entries[head + sq_idx_t'(i)].address;
            cache_write[i].data    = entries[head + sq_idx_t'(i)].data;
        end
    end

    // ====================
    // Forwarding search
    // ====================

    // Walk from just below the load's tail back to head, youngest first
    always_comb begin
        found = 1'b0;
        span  = '0;
        idx   = '0;
        for (int p = 0; p < `LSQ_NUM_MEM; p++) begin
            fwd[p] = '0;
            found  = 1'b0;
            // Number of stores older than the load
            span   = lookup[p].sq_tail - head;
            for (int s = 0; s < `LSQ_SZ; s++) begin
                idx = lookup[p].sq_tail - sq_idx_t'(s) - sq_idx_t'(1);
                // Word match only, byte offset ignored
                if (lookup[p].valid && !found && (s < span) && entries[idx].valid &&
                    (entries[idx].address[`LSQ_ADDR_W-1:2] ==
                     lookup[p].address[`LSQ_ADDR_W-1:2])) begin
                    found        = 1'b1;
                    fwd[p].hit   = executed[idx];
                    fwd[p].stall = !executed[idx];
                    fwd[p].data  = entries[idx].data;
                end
            end
        end
    end

    // ====================
    // Registers
    // ====================

    // Mispredict empties the queue in one cycle
    always_ff @(posedge clock) begin
        if (!rst_n || mispredict) begin
            for (int i = 0; i < `LSQ_SZ; i++) begin
                entries[i].valid <= 1'b0;
            end
            executed <= '0;
            head     <= '0;
            tail     <= '0;
            free_cnt <= sq_count_t'(`LSQ_SZ);
        end else begin
            entries  <= entries_next;
            executed <= executed_next;
            head     <= head_next;
            tail     <= tail_next;
            free_cnt <= free_next;
        end
    end

    // Core retires only stores that are present and executed
    for (genvar i = 0; i < `LSQ_N; i++) begin : g_retire_chk
        a_retire_ready: assert property (@(posedge clock) disable iff (!rst_n)
            (free_count > i) |->
            (entries[head + sq_idx_t'(i)].valid && executed[head + sq_idx_t'(i)]));
    end

    // Core never dispatches past the free slots
    a_disp_fits: assert property (@(posedge clock) disable iff (!rst_n)
        sq_count_t'(num_disp) <= free_cnt);

    // Memory units only update live slots
    for (genvar p = 0; p < `LSQ_NUM_MEM; p++) begin : g_exec_chk
        a_exec_live: assert property (@(posedge clock) disable iff (!rst_n)
            exec[p].valid |-> entries[exec[p].sq_idx].valid);
    end

endmodule

// ==== hw/load_pipe.sv ====
// Per-unit load sequencer FSM with store queue lookup, stall and cache read
`timescale 1ns/100ps
`include "lsq_params.svh"

module load_pipe (
    input  logic                  clock,
    input  logic                  rst_n,
    // Request from the core
    input  lsq_pkg::load_req_t    req,
    output logic                  busy,
    // Store queue query, answered in the same cycle
    output lsq_pkg::sq_lookup_t   lookup,
    input  lsq_pkg::sq_fwd_t      fwd,
    // Cache read, data one edge later
    output lsq_pkg::addr_t        read_addr,
    input  lsq_pkg::data_t        read_data,
    // Finished load
    output lsq_pkg::load_result_t result
);
    import lsq_pkg::*;

    load_state_t state;
    load_state_t state_next;

    // Accepted request
    addr_t   held_addr;
    sq_idx_t held_tail;

    assign busy = (state != IDLE);

    // Query repeats every cycle while in LOOKUP
    assign lookup.valid   = (state == LOOKUP);
    assign lookup.address = held_addr;
    assign lookup.sq_tail = held_tail;

    // Cache sees the held address, sampled on the edge leaving LOOKUP
    assign read_addr = held_addr;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (req.valid) state_next = LOOKUP;
            end
            LOOKUP: begin
                // Stall keeps us here until the store executes or retires
                if (fwd.hit) state_next = IDLE;
                else if (!fwd.stall) state_next = READ;
            end
            READ:    state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state        <= IDLE;
            result.valid <= 1'b0;
        end else begin
            state        <= state_next;
            result.valid <= (state == LOOKUP && fwd.hit) || (state == READ);
        end
        // Payload
        if (state == IDLE && req.valid) begin
            held_addr <= req.address;
            held_tail <= req.sq_tail;
        end
        if (state == LOOKUP) begin
            result.forwarded <= 1'b1;
            result.data      <= fwd.data;
        end else if (state == READ) begin
            result.forwarded <= 1'b0;
            result.data      <= read_data;
        end
    end

    // Core holds loads back while the pipe is occupied
    a_no_req_busy: assert property (@(posedge clock) disable iff (!rst_n)
        busy |-> !req.valid);

endmodule

// ==== hw/data_cache.sv ====
// Word-addressed store-only data memory with retire write ports and registered load reads
`timescale 1ns/100ps
`include "lsq_params.svh"

module data_cache (
    input  logic                                     clock,
    input  logic                                     rst_n,
    // Retire writes, oldest store in port 0
    input  lsq_pkg::cache_write_t [`LSQ_N-1:0]       write,
    // One read port per load pipe
    input  lsq_pkg::addr_t        [`LSQ_NUM_MEM-1:0] read_addr,
    output lsq_pkg::data_t        [`LSQ_NUM_MEM-1:0] read_data
);
    import lsq_pkg::*;

    localparam int IDX_W = $clog2(`LSQ_CACHE_WORDS);

    data_t mem [`LSQ_CACHE_WORDS];

    // Word index, byte offset dropped and upper bits wrap
    function automatic logic [IDX_W-1:0] word_idx(input addr_t addr);
        return addr[IDX_W+1:2];
    endfunction

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int w = 0; w < `LSQ_CACHE_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else begin
            // Higher port written last, so the younger store wins a collision
            for (int i = 0; i < `LSQ_N; i++) begin
                if (write[i].valid) begin
                    mem[word_idx(write[i].address)] <= write[i].data;
                end
            end
        end
        // Reads see the word before this edge's writes
        for (int p = 0; p < `LSQ_NUM_MEM; p++) begin
            read_data[p] <= mem[word_idx(read_addr[p])];
        end
    end

endmodule

// ==== hw/lsq_top.sv ====
// Top level with the store queue, the data cache and one load pipe per memory unit
`timescale 1ns/100ps
`include "lsq_params.svh"

module lsq_top (
    input  logic                                      clock,
    input  logic                                      rst_n,
    // Dispatch
    input  lsq_pkg::sq_entry_t     [`LSQ_N-1:0]       dispatch,
    output lsq_pkg::sq_count_t                        free_slots,
    output lsq_pkg::sq_idx_t       [`LSQ_N-1:0]       alloc_idxs,
    output lsq_pkg::sq_idx_t                          tail_idx,
    // Store execute
    input  lsq_pkg::sq_exec_t      [`LSQ_NUM_MEM-1:0] exec,
    // Retire and recovery
    input  logic                                      mispredict,
    input  lsq_pkg::retire_count_t                    free_count,
    output logic                                      unexecuted_store,
    // Loads
    input  lsq_pkg::load_req_t     [`LSQ_NUM_MEM-1:0] load_req,
    output logic                   [`LSQ_NUM_MEM-1:0] load_busy,
    output lsq_pkg::load_result_t  [`LSQ_NUM_MEM-1:0] load_result
);
    import lsq_pkg::*;

    // Pipe to queue
    sq_lookup_t   [`LSQ_NUM_MEM-1:0] lookups;
    sq_fwd_t      [`LSQ_NUM_MEM-1:0] fwds;
    // Pipe to cache
    addr_t        [`LSQ_NUM_MEM-1:0] read_addrs;
    data_t        [`LSQ_NUM_MEM-1:0] read_datas;
    // Queue to cache
    cache_write_t [`LSQ_N-1:0]       cache_writes;

    store_queue store_queue_inst (
        .clock            (clock),
        .rst_n            (rst_n),
        .dispatch         (dispatch),
        .free_slots       (free_slots),
        .alloc_idxs       (alloc_idxs),
        .tail_idx         (tail_idx),
        .exec             (exec),
        .lookup           (lookups),
        .fwd              (fwds),
        .mispredict       (mispredict),
        .free_count       (free_count),
        .unexecuted_store (unexecuted_store),
        .cache_write      (cache_writes)
    );

    data_cache data_cache_inst (
        .clock     (clock),
        .rst_n     (rst_n),
        .write     (cache_writes),
        .read_addr (read_addrs),
        .read_data (read_datas)
    );

    // One load pipe per memory unit
    for (genvar m = 0; m < `LSQ_NUM_MEM; m++) begin : g_load_pipe
        load_pipe load_pipe_inst (
            .clock     (clock),
            .rst_n     (rst_n),
            .req       (load_req[m]),
            .busy      (load_busy[m]),
            .lookup    (lookups[m]),
            .fwd       (fwds[m]),
            .read_addr (read_addrs[m]),
            .read_data (read_datas[m]),
            .result    (load_result[m])
        );
    end

endmodule

// ==== verif/lsq_tb.sv ====
// Directed testbench for lsq_top with store model, reference memory, compare tasks and timeout
`timescale 1ns/100ps
`include "lsq_params.svh"

module lsq_tb;
    import lsq_pkg::*;

    localparam int NM        = `LSQ_NUM_MEM;
    localparam int WORD_BITS = $clog2(`LSQ_CACHE_WORDS);
    // Far above the few hundred cycles of the whole run
    localparam int TIMEOUT_CYCLES  = 4000;
    // Longest a single load may take once its store has executed
    localparam int LOAD_WAIT_LIMIT = 20;

    // In-flight store as the testbench tracks it
    typedef struct packed {
        addr_t   address;
        data_t   data;
        sq_idx_t slot;
    } store_rec_t;

    logic                        clock;
    logic                        rst_n;
    sq_entry_t     [`LSQ_N-1:0]  dispatch;
    sq_count_t                   free_slots;
    sq_idx_t       [`LSQ_N-1:0]  alloc_idxs;
    sq_idx_t                     tail_idx;
    sq_exec_t      [NM-1:0]      exec;
    logic                        mispredict;
    retire_count_t               free_count;
    logic                        unexecuted_store;
    load_req_t     [NM-1:0]      load_req;
    logic          [NM-1:0]      load_busy;
    load_result_t  [NM-1:0]      load_result;

    // Model state, oldest in-flight store at the front
    store_rec_t   inflight [$];
    data_t        ref_mem [`LSQ_CACHE_WORDS];
    sq_idx_t      model_tail;
    int           model_free;
    load_result_t got [NM];
    integer       seed;
    string        test_name;
    int           error_count;
    int           check_total;
    int           cycle_count = 0;

    lsq_top lsq_top_inst (
        .clock            (clock),
        .rst_n            (rst_n),
        .dispatch         (dispatch),
        .free_slots       (free_slots),
        .alloc_idxs       (alloc_idxs),
        .tail_idx         (tail_idx),
        .exec             (exec),
        .mispredict       (mispredict),
        .free_count       (free_count),
        .unexecuted_store (unexecuted_store),
        .load_req         (load_req),
        .load_busy        (load_busy),
        .load_result      (load_result)
    );

    // ====================
    // Clock and timeout
    // ====================

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
        $display("Checks: %0d  Errors: %0d", check_total, error_count);
        $display("Test failed");
        $finish;
    end

    // ====================
    // Compare tasks
    // ====================

    task automatic check_data(input string what, input data_t exp, input data_t act);
        check_total++;
        if (exp !== act) begin
            error_count++;
            $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input sq_count_t exp, input sq_count_t act);
        check_total++;
        if (exp !== act) begin
            error_count++;
            $display("ERR %s %s: expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_index(input string what, input sq_idx_t exp, input sq_idx_t act);
        check_total++;
        if (exp !== act) begin
            error_count++;
            $display("ERR %s %s: expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        check_total++;
        if (exp !== act) begin
            error_count++;
            $display("ERR %s %s: expected %0b actual %0b", test_name, what, exp, act);
        end
    endtask

    // Forwarded flag and data of a finished load
    task automatic check_result(input string what, input load_result_t exp,
                                input load_result_t act);
        check_total++;
        if (exp.forwarded !== act.forwarded || exp.data !== act.data) begin
            error_count++;
            $display("ERR %s %s: expected fwd=%0b data=%h actual fwd=%0b data=%h",
                     test_name, what, exp.forwarded, exp.data, act.forwarded, act.data);
        end
    endtask

    // ====================
    // Model helpers
    // ====================

    function automatic addr_t rand_addr();
        return addr_t'($random(seed)) & ~addr_t'(3);
    endfunction

    function automatic data_t rand_data();
        return data_t'($random(seed));
    endfunction

    // Cache word index with the upper address bits wrapping
    function automatic int word_of(input addr_t a);
        return int'(a[WORD_BITS+1:2]);
    endfunction

    // Youngest matching store among the older ones, or the memory word when none match
    function automatic load_result_t expected_load(input addr_t addr, input int older);
        load_result_t exp;
        logic         found;
        exp.valid     = 1'b1;
        exp.forwarded = 1'b0;
        exp.data      = ref_mem[word_of(addr)];
        found         = 1'b0;
        for (int i = older - 1; i >= 0; i--) begin
            if (!found && inflight[i].address[31:2] == addr[31:2]) begin
                found         = 1'b1;
                exp.forwarded = 1'b1;
                exp.data      = inflight[i].data;
            end
        end
        return exp;
    endfunction

    // ====================
    // Drivers
    // ====================

    // Inputs change and outputs are sampled 1 ns past the edge
    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic dispatch_stores(input int count, input addr_t first, input addr_t second);
        addr_t      addrs [2];
        store_rec_t rec;
        addrs[0] = first;
        addrs[1] = second;
        dispatch = '0;
        for (int i = 0; i < count; i++) begin
            check_index("alloc_idxs", model_tail + sq_idx_t'(i), alloc_idxs[i]);
            // Lone store rides in the upper slot so packing has a gap to close
            dispatch[(count == 1) ? 1 : i] = '{valid: 1'b1, address: addrs[i], data: '0};
            rec = '{address: addrs[i], data: '0, slot: model_tail + sq_idx_t'(i)};
            inflight.push_back(rec);
        end
        model_tail = model_tail + sq_idx_t'(count);
        model_free = model_free - count;
        next_cycle();
        dispatch = '0;
        check_count("free_slots after dispatch", sq_count_t'(model_free), free_slots);
        check_index("tail_idx after dispatch", model_tail, tail_idx);
    endtask

    // pos counts from the oldest in-flight store
    task automatic execute_store(input int port, input int pos, input data_t value);
        store_rec_t rec;
        rec            = inflight[pos];
        rec.data       = value;
        inflight[pos]  = rec;
        exec[port]     = '{valid: 1'b1, sq_idx: rec.slot, address: rec.address, data: value};
        next_cycle();
        exec = '0;
    endtask

    task automatic retire_stores(input int count);
        store_rec_t rec;
        free_count = retire_count_t'(count);
        // Older store written first and the younger one owns a shared word
        for (int i = 0; i < count; i++) begin
            rec = inflight.pop_front();
            ref_mem[word_of(rec.address)] = rec.data;
        end
        model_free = model_free + count;
        next_cycle();
        free_count = '0;
        check_count("free_slots after retire", sq_count_t'(model_free), free_slots);
    endtask

    task automatic flush_queue();
        mispredict = 1'b1;
        next_cycle();
        mispredict = 1'b0;
        inflight.delete();
        model_tail = '0;
        model_free = `LSQ_SZ;
    endtask

    task automatic present_load(input int pipe, input addr_t addr, input sq_idx_t tail);
        if (load_busy[pipe]) begin
            error_count++;
            $display("Load pipe %0d still busy when a new load was presented", pipe);
        end
        load_req[pipe] = '{valid: 1'b1, address: addr, sq_tail: tail};
    endtask

    task automatic accept_loads();
        next_cycle();
        load_req = '0;
    endtask

    // Wait for one result pulse on every pipe in the mask
    task automatic collect_results(input logic [NM-1:0] mask);
        logic [NM-1:0] seen;
        int            waited;
        seen   = '0;
        waited = 0;
        while ((seen & mask) != mask && waited < LOAD_WAIT_LIMIT) begin
            next_cycle();
            waited++;
            for (int p = 0; p < NM; p++) begin
                if (mask[p] && !seen[p] && load_result[p].valid) begin
                    got[p]  = load_result[p];
                    seen[p] = 1'b1;
                end
            end
        end
        for (int p = 0; p < NM; p++) begin
            if (mask[p] && !seen[p]) begin
                error_count++;
                $display("Load on pipe %0d gave no result within %0d cycles", p, waited);
            end
        end
    endtask

    task automatic run_load(input int pipe, input addr_t addr, input sq_idx_t tail,
                            input int older, input string what);
        load_result_t  exp;
        logic [NM-1:0] mask;
        exp        = expected_load(addr, older);
        mask       = '0;
        mask[pipe] = 1'b1;
        got[pipe]  = '0;
        present_load(pipe, addr, tail);
        accept_loads();
        collect_results(mask);
        check_result(what, exp, got[pipe]);
    endtask

    // ====================
    // Directed tests
    // ====================

    task automatic dispatch_and_wrap();
        test_name = "dispatch_and_wrap";
        check_count("free_slots after reset", sq_count_t'(`LSQ_SZ), free_slots);
        check_flag("unexecuted_store after reset", 1'b0, unexecuted_store);
        check_index("tail_idx after reset", '0, tail_idx);
        // Two, one, two, two leaves one slot free
        dispatch_stores(2, rand_addr(), rand_addr());
        dispatch_stores(1, rand_addr(), '0);
        dispatch_stores(2, rand_addr(), rand_addr());
        dispatch_stores(2, rand_addr(), rand_addr());
        check_count("free_slots with seven queued", sq_count_t'(1), free_slots);
        check_flag("unexecuted_store with stores queued", 1'b1, unexecuted_store);
        for (int i = 0; i < 7; i++) begin
            execute_store(i % NM, i, rand_data());
        end
        retire_stores(2);
        retire_stores(2);
        retire_stores(2);
        retire_stores(1);
        // Tail sits at 7 and the next pair wraps into slots 7 and 0
        check_index("tail_idx before wrap", sq_idx_t'(7), tail_idx);
        dispatch_stores(2, rand_addr(), rand_addr());
        check_index("tail_idx after wrap", sq_idx_t'(1), tail_idx);
        execute_store(0, 0, rand_data());
        execute_store(1, 1, rand_data());
        retire_stores(2);
    endtask

    task automatic forward_youngest();
        addr_t   a;
        sq_idx_t tail;
        int      older;
        test_name = "forward_youngest";
        a = rand_addr();
        dispatch_stores(2, a, a);
        execute_store(0, 0, rand_data());
        execute_store(1, 1, rand_data());
        // Load dispatched here behind both stores
        tail  = model_tail;
        older = inflight.size();
        // Younger store to the same word stays invisible to that load
        dispatch_stores(1, a, '0);
        execute_store(0, 2, rand_data());
        run_load(0, a + addr_t'(3), tail, older, "load behind two stores");
        retire_stores(2);
        retire_stores(1);
    endtask

    task automatic stall_until_execute();
        addr_t b;
        test_name = "stall_until_execute";
        b = rand_addr();
        dispatch_stores(1, b, '0);
        check_flag("unexecuted_store before execute", 1'b1, unexecuted_store);
        present_load(0, b, model_tail);
        accept_loads();
        // Pipe keeps asking while the store has no data
        repeat (5) begin
            next_cycle();
            check_flag("busy while stalled", 1'b1, load_busy[0]);
            check_flag("result while stalled", 1'b0, load_result[0].valid);
        end
        execute_store(0, 0, rand_data());
        check_flag("unexecuted_store after execute", 1'b0, unexecuted_store);
        got[0] = '0;
        collect_results(2'b01);
        check_result("stalled load", expected_load(b, 1), got[0]);
        retire_stores(1);
    endtask

    task automatic cache_after_retire();
        addr_t c;
        data_t c_val;
        test_name = "cache_after_retire";
        c     = rand_addr();
        c_val = rand_data();
        // Partner store two words up never shares a cache word with c
        dispatch_stores(2, c, c + addr_t'(8));
        execute_store(0, 0, c_val);
        execute_store(1, 1, rand_data());
        retire_stores(2);
        run_load(1, c, model_tail, 0, "load from empty queue");
        // Cache word holds exactly what the retired store carried
        check_data("cache against retired store", c_val, got[1].data);
        // Older store to the neighbouring word must not forward
        dispatch_stores(1, c + addr_t'(4), '0);
        execute_store(1, 0, rand_data());
        run_load(1, c, model_tail, inflight.size(), "load past other word");
        run_load(0, rand_addr(), model_tail, inflight.size(), "load of random word");
        retire_stores(1);
    endtask

    task automatic flush_on_mispredict();
        addr_t e;
        addr_t f;
        test_name = "flush_on_mispredict";
        e = rand_addr();
        f = rand_addr();
        // Retired values first so squashed data would show up
        dispatch_stores(2, e, f);
        execute_store(0, 0, rand_data());
        execute_store(1, 1, rand_data());
        retire_stores(2);
        dispatch_stores(2, e, f);
        execute_store(0, 0, rand_data());
        check_flag("unexecuted_store before flush", 1'b1, unexecuted_store);
        flush_queue();
        check_count("free_slots after flush", sq_count_t'(`LSQ_SZ), free_slots);
        check_flag("unexecuted_store after flush", 1'b0, unexecuted_store);
        check_index("tail_idx after flush", '0, tail_idx);
        run_load(0, e, model_tail, 0, "load of squashed word e");
        run_load(1, f, model_tail, 0, "load of squashed word f");
    endtask

    task automatic dual_pipe_loads();
        addr_t        g;
        addr_t        h;
        load_result_t exp_fwd;
        load_result_t exp_cache;
        test_name = "dual_pipe_loads";
        g = rand_addr();
        h = g + addr_t'(4);
        dispatch_stores(1, g, '0);
        execute_store(1, 0, rand_data());
        exp_fwd   = expected_load(g, 1);
        exp_cache = expected_load(h, 1);
        got[0]    = '0;
        got[1]    = '0;
        present_load(0, g, model_tail);
        present_load(1, h, model_tail);
        accept_loads();
        collect_results('1);
        check_result("pipe 0 forwarded", exp_fwd, got[0]);
        check_result("pipe 1 from cache", exp_cache, got[1]);
        retire_stores(1);
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        seed        = 32'hc3df;
        rst_n       = 1'b0;
        dispatch    = '0;
        exec        = '0;
        mispredict  = 1'b0;
        free_count  = '0;
        load_req    = '0;
        model_tail  = '0;
        model_free  = `LSQ_SZ;
        error_count = 0;
        check_total = 0;
        test_name   = "reset";
        for (int w = 0; w < `LSQ_CACHE_WORDS; w++) begin
            ref_mem[w] = '0;
        end
        repeat (3) @(posedge clock);
        #1 rst_n = 1'b1;

        dispatch_and_wrap();
        forward_youngest();
        stall_until_execute();
        cache_after_retire();
        flush_on_mispredict();
        dual_pipe_loads();

        $display("Checks: %0d  Errors: %0d", check_total, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== store_forward.f ====
+incdir+hw
hw/lsq_pkg.sv
hw/store_queue.sv
hw/load_pipe.sv
hw/data_cache.sv
hw/lsq_top.sv
verif/lsq_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the store_forward testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --assert --timescale 1ns/100ps --top-module lsq_tb \
    -f store_forward.f -Mdir "$BUILD_DIR" -o lsq_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/lsq_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Test passed" "$LOG"; then
    echo "Simulation log holds no result line"
    exit 1
fi
exit 0
